// File: src/z80_pkg.sv
package z80_pkg;

  // ---------------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------------

  // every general register, the accumulator and the ALU operands share one width
  localparam int data_w = 8;

  // the half-carry comes out of the low nibble
  localparam int nib_w = 4;

  // number of general registers in each bank, B C D E H L
  localparam int num_regs = 6;

  // ---------------------------------------------------------------------------
  // flag bit positions in F
  // ---------------------------------------------------------------------------

  // bits 5 and 3 carry nothing and stay at zero
  localparam int flag_s  = 7;
  localparam int flag_z  = 6;
  localparam int flag_h  = 4;
  localparam int flag_pv = 2;
  localparam int flag_n  = 1;
  localparam int flag_c  = 0;

  // general register codes. codes 6 and 7 select nothing
  typedef enum logic [2:0] {
    b = 3'd0,
    c = 3'd1,
    d = 3'd2,
    e = 3'd3,
    h = 3'd4,
    l = 3'd5
  } reg_e;

  // functions of the 8-bit ALU, the left operand is always A
  typedef enum logic [2:0] {
    alu_pass = 3'd0,
    alu_inc  = 3'd1,
    alu_dec  = 3'd2,
    alu_add  = 3'd3,
    alu_sub  = 3'd4
  } alu_op_e;

  // micro-operations taken from the outside, one per clock
  typedef enum logic [3:0] {
    uop_nop    = 4'd0,
    uop_ld_reg = 4'd1,
    uop_ld_a   = 4'd2,
    uop_mov_a  = 4'd3,
    uop_add    = 4'd4,
    uop_sub    = 4'd5,
    uop_inc_a  = 4'd6,
    uop_dec_a  = 4'd7,
    uop_exx    = 4'd8,
    uop_ex_af  = 4'd9,
    uop_swap_a = 4'd10,
    uop_read   = 4'd11
  } uop_e;

  // what the accumulator loads from when it is written
  typedef enum logic [1:0] {
    acc_src_data = 2'd0,
    acc_src_alu  = 2'd1,
    acc_src_reg  = 2'd2
  } acc_src_e;

endpackage

// File: src/uop_decode.sv
module uop_decode (
  input  logic              op_valid,
  input  z80_pkg::uop_e     op,
  output logic              wr_reg,
  output logic              wr_acc,
  output logic              wr_flags,
  output logic              exx,
  output logic              ex_af,
  output logic              swap_a,
  output logic              rd_en,
  output z80_pkg::acc_src_e acc_src,
  output z80_pkg::alu_op_e  alu_op
);

  // one micro-op maps onto a set of one-cycle enables for the register bank
  // nothing here holds state, the whole decode settles within the cycle
  always_comb begin
    // quiet defaults, an idle cycle or an unknown code changes nothing
    wr_reg   = 1'b0;
    wr_acc   = 1'b0;
    wr_flags = 1'b0;
    exx      = 1'b0;
    ex_af    = 1'b0;
    swap_a   = 1'b0;
    rd_en    = 1'b0;
    acc_src  = z80_pkg::acc_src_data;
    alu_op   = z80_pkg::alu_pass;

    if (op_valid) begin
      case (op)
        z80_pkg::uop_ld_reg: wr_reg = 1'b1;
        z80_pkg::uop_ld_a: begin
          wr_acc  = 1'b1;
          acc_src = z80_pkg::acc_src_data;
        end
        // the register reaches A through the ALU in pass mode
        z80_pkg::uop_mov_a: begin
          wr_acc  = 1'b1;
          acc_src = z80_pkg::acc_src_alu;
          alu_op  = z80_pkg::alu_pass;
        end
        z80_pkg::uop_add: begin
          wr_acc   = 1'b1;
          wr_flags = 1'b1;
          acc_src  = z80_pkg::acc_src_alu;
          alu_op   = z80_pkg::alu_add;
        end
        z80_pkg::uop_sub: begin
          wr_acc   = 1'b1;
          wr_flags = 1'b1;
          acc_src  = z80_pkg::acc_src_alu;
          alu_op   = z80_pkg::alu_sub;
        end
        // increment leaves F alone, so F is not written at all
        z80_pkg::uop_inc_a: begin
          wr_acc  = 1'b1;
          acc_src = z80_pkg::acc_src_alu;
          alu_op  = z80_pkg::alu_inc;
        end
        z80_pkg::uop_dec_a: begin
          wr_acc   = 1'b1;
          wr_flags = 1'b1;
          acc_src  = z80_pkg::acc_src_alu;
          alu_op   = z80_pkg::alu_dec;
        end
        z80_pkg::uop_exx:   exx   = 1'b1;
        z80_pkg::uop_ex_af: ex_af = 1'b1;
        // A takes the register directly while the register takes the old A
        z80_pkg::uop_swap_a: begin
          swap_a  = 1'b1;
          wr_acc  = 1'b1;
          acc_src = z80_pkg::acc_src_reg;
        end
        z80_pkg::uop_read: rd_en = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: src/alu8.sv
module alu8 (
  input  logic [z80_pkg::data_w-1:0] acc_q,
  input  logic [z80_pkg::data_w-1:0] operand,
  input  logic [7:0]                 flags_q,
  input  z80_pkg::alu_op_e           alu_op,
  output logic [z80_pkg::data_w-1:0] alu_result,
  output logic [7:0]                 alu_flags
);

  // right-hand operand of the shared adder, either the register or a one
  logic [z80_pkg::data_w-1:0] rhs;
  // high when the adder subtracts instead of adds
  logic                       sub_mode;
  // low nibble with its carry or borrow bit on top
  logic [z80_pkg::nib_w:0]    nib_q;
  // full byte with its carry or borrow bit on top
  logic [z80_pkg::data_w:0]   sum_q;

  // ---------------------------------------------------------------------------
  // one adder serves inc, dec, add and sub
  // ---------------------------------------------------------------------------

  always_comb begin
    rhs = operand;
    // inc and dec step A by one, so the operand is replaced by a constant one
    if (alu_op == z80_pkg::alu_inc || alu_op == z80_pkg::alu_dec) begin
      rhs    = '0;
      rhs[0] = 1'b1;
    end
  end

  assign sub_mode = (alu_op == z80_pkg::alu_sub) || (alu_op == z80_pkg::alu_dec);

  // the extra top bit of each partial sum is the carry out, or in subtract
  // mode the borrow, since a zero-extended difference wraps into it
  always_comb begin
    if (sub_mode) begin
      nib_q = {1'b0, acc_q[z80_pkg::nib_w-1:0]} - {1'b0, rhs[z80_pkg::nib_w-1:0]};
      sum_q = {1'b0, acc_q} - {1'b0, rhs};
    end else begin
      nib_q = {1'b0, acc_q[z80_pkg::nib_w-1:0]} + {1'b0, rhs[z80_pkg::nib_w-1:0]};
      sum_q = {1'b0, acc_q} + {1'b0, rhs};
    end
  end

  // ---------------------------------------------------------------------------
  // result select and flag rules
  // ---------------------------------------------------------------------------

  always_comb begin
    // flags not named by a rule keep their old value
    alu_flags  = flags_q;
    alu_result = sum_q[z80_pkg::data_w-1:0];

    case (alu_op)
      z80_pkg::alu_add, z80_pkg::alu_sub: begin
        alu_flags[z80_pkg::flag_h] = nib_q[z80_pkg::nib_w];
        alu_flags[z80_pkg::flag_c] = sum_q[z80_pkg::data_w];
        alu_flags[z80_pkg::flag_s] = sum_q[z80_pkg::data_w-1];
        alu_flags[z80_pkg::flag_z] = (sum_q[z80_pkg::data_w-1:0] == '0);
        // N remembers whether the last arithmetic was a subtraction
        alu_flags[z80_pkg::flag_n] = sub_mode;
      end
      // PV here only says whether the decrement left something behind
      z80_pkg::alu_dec: alu_flags[z80_pkg::flag_pv] = |sum_q[z80_pkg::data_w-1:0];
      z80_pkg::alu_inc: ;
      // pass and any unused code hand the operand straight through
      default: alu_result = operand;
    endcase
  end

endmodule

// File: src/reg_bank.sv
module reg_bank (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       wr_reg,
  input  logic                       wr_acc,
  input  logic                       wr_flags,
  input  logic                       exx,
  input  logic                       ex_af,
  input  logic                       swap_a,
  input  logic                       rd_en,
  input  z80_pkg::acc_src_e          acc_src,
  input  z80_pkg::reg_e              reg_sel,
  input  logic [z80_pkg::data_w-1:0] data_in,
  input  logic [z80_pkg::data_w-1:0] alu_result,
  input  logic [7:0]                 alu_flags,
  output logic [z80_pkg::data_w-1:0] operand,
  output logic [z80_pkg::data_w-1:0] acc_q,
  output logic [z80_pkg::data_w-1:0] data_out,
  output logic [7:0]                 flags_q,
  output logic                       data_valid
);

  // main bank and its shadow, indexed by the register code
  logic [z80_pkg::data_w-1:0] main_q   [z80_pkg::num_regs];
  logic [z80_pkg::data_w-1:0] shadow_q [z80_pkg::num_regs];

  // shadow accumulator and shadow flags
  logic [z80_pkg::data_w-1:0] acc_sh_q;
  logic [7:0]                 flags_sh_q;

  // high when reg_sel names a real register
  logic                       sel_ok;
  // next value of A
  logic [z80_pkg::data_w-1:0] acc_d;

  // ---------------------------------------------------------------------------
  // read side
  // ---------------------------------------------------------------------------

  assign sel_ok = (reg_sel <= z80_pkg::l);

  // unused codes read as zero instead of running off the end of the array
  assign operand = sel_ok ? main_q[reg_sel] : '0;

  always_comb begin
    case (acc_src)
      z80_pkg::acc_src_alu: acc_d = alu_result;
      // point-to-point path from the selected register for the swap
      z80_pkg::acc_src_reg: acc_d = operand;
      default:              acc_d = data_in;
    endcase
  end

  // ---------------------------------------------------------------------------
  // general registers
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < z80_pkg::num_regs; i++) begin
        main_q[i]   <= '0;
        shadow_q[i] <= '0;
      end
    end else begin
      // the whole bank trades places with its shadow in one edge
      if (exx) begin
        for (int i = 0; i < z80_pkg::num_regs; i++) begin
          main_q[i]   <= shadow_q[i];
          shadow_q[i] <= main_q[i];
        end
      end
      // an unused code writes nothing
      if (wr_reg && sel_ok) begin
        main_q[reg_sel] <= data_in;
      end
      // the other half of the swap, the register takes the old A
      if (swap_a && sel_ok) begin
        main_q[reg_sel] <= acc_q;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // accumulator and flags
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_q      <= '0;
      acc_sh_q   <= '0;
      flags_q    <= '0;
      flags_sh_q <= '0;
    end else if (ex_af) begin
      // A and F go over to the shadow pair together
      acc_q      <= acc_sh_q;
      acc_sh_q   <= acc_q;
      flags_q    <= flags_sh_q;
      flags_sh_q <= flags_q;
    end else begin
      if (wr_acc) begin
        acc_q <= acc_d;
      end
      if (wr_flags) begin
        flags_q <= alu_flags;
      end
    end
  end

  // read port, data_out holds its last value and data_valid marks a fresh one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out   <= '0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= rd_en;
      if (rd_en) begin
        data_out <= operand;
      end
    end
  end

endmodule

// File: src/z80_datapath.sv
module z80_datapath (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       op_valid,
  input  z80_pkg::uop_e              op,
  input  z80_pkg::reg_e              reg_sel,
  input  logic [z80_pkg::data_w-1:0] data_in,
  output logic [z80_pkg::data_w-1:0] acc,
  output logic [7:0]                 flags,
  output logic [z80_pkg::data_w-1:0] data_out,
  output logic                       data_valid
);

  // decode to register bank enables
  logic                       wr_reg;
  logic                       wr_acc;
  logic                       wr_flags;
  logic                       exx;
  logic                       ex_af;
  logic                       swap_a;
  logic                       rd_en;
  z80_pkg::acc_src_e          acc_src;
  z80_pkg::alu_op_e           alu_op;

  // register bank to ALU and back
  logic [z80_pkg::data_w-1:0] operand;
  logic [z80_pkg::data_w-1:0] alu_result;
  logic [7:0]                 alu_flags;
  logic [z80_pkg::data_w-1:0] acc_q_w;
  logic [7:0]                 flags_q_w;

  // A and F are read by the ALU and seen outside
  assign acc   = acc_q_w;
  assign flags = flags_q_w;

  uop_decode uop_decode_inst (
    .op_valid (op_valid),
    .op       (op),
    .wr_reg   (wr_reg),
    .wr_acc   (wr_acc),
    .wr_flags (wr_flags),
    .exx      (exx),
    .ex_af    (ex_af),
    .swap_a   (swap_a),
    .rd_en    (rd_en),
    .acc_src  (acc_src),
    .alu_op   (alu_op)
  );

  alu8 alu8_inst (
    .acc_q      (acc_q_w),
    .operand    (operand),
    .flags_q    (flags_q_w),
    .alu_op     (alu_op),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  // every write lands at the edge that takes the micro-op
  reg_bank reg_bank_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_reg     (wr_reg),
    .wr_acc     (wr_acc),
    .wr_flags   (wr_flags),
    .exx        (exx),
    .ex_af      (ex_af),
    .swap_a     (swap_a),
    .rd_en      (rd_en),
    .acc_src    (acc_src),
    .reg_sel    (reg_sel),
    .data_in    (data_in),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .operand    (operand),
    .acc_q      (acc_q_w),
    .data_out   (data_out),
    .flags_q    (flags_q_w),
    .data_valid (data_valid)
  );

endmodule

// File: tests/z80_datapath_chk.sv
module z80_datapath_chk (
  input logic          clk,
  input logic          arst_n,
  input logic          op_valid,
  input z80_pkg::uop_e op,
  input logic [7:0]    acc,
  input logic [7:0]    flags,
  input logic          data_valid
);

  // a read is taken at an edge where op_valid is high with uop_read
  logic read_taken;
  assign read_taken = op_valid && (op == z80_pkg::uop_read);

  // each cycle of data_valid stands for a read taken at the edge before it
  assert property (@(posedge clk) disable iff (!arst_n)
    data_valid && $past(data_valid) |-> $past(read_taken) && $past(read_taken, 2))
    else $error("data_valid held over a cycle without a read");

  // the two unused bits of F never leave zero
  assert property (@(posedge clk) disable iff (!arst_n)
    !flags[5] && !flags[3])
    else $error("unused flag bit set");

  assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(acc))
    else $error("acc carries an unknown value");

endmodule

bind z80_datapath z80_datapath_chk z80_datapath_chk_inst (
  .clk        (clk),
  .arst_n     (arst_n),
  .op_valid   (op_valid),
  .op         (op),
  .acc        (acc),
  .flags      (flags),
  .data_valid (data_valid)
);

// File: tests/tb_z80_datapath.sv
module tb_z80_datapath;

  // ---------------------------------------------------------------------------
  // run length and timing
  // ---------------------------------------------------------------------------

  localparam int clk_half     = 10;
  localparam int reset_cycles = 5;
  localparam int num_cycles   = 2000;
  localparam int margin       = 50;
  // the run ends well before this unless something stalls it
  localparam int cycle_limit  = reset_cycles + num_cycles + margin;
  localparam int drive_delay  = 2;
  localparam int check_delay  = 1;
  localparam int num_regs     = 6;

  logic              clk;
  logic              arst_n;
  logic              op_valid;
  z80_pkg::uop_e     op;
  z80_pkg::reg_e     reg_sel;
  logic [7:0]        data_in;
  logic [7:0]        acc;
  logic [7:0]        flags;
  logic [7:0]        data_out;
  logic              data_valid;

  // reference model state, main bank, shadow bank, A, F and the read port
  logic [7:0]        model_main   [num_regs];
  logic [7:0]        model_shadow [num_regs];
  logic [7:0]        model_acc;
  logic [7:0]        model_acc_sh;
  logic [7:0]        model_flags;
  logic [7:0]        model_flags_sh;
  logic [7:0]        model_dout;
  logic              model_dvalid;

  int                cycle_count;

  z80_datapath z80_datapath_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .op_valid   (op_valid),
    .op         (op),
    .reg_sel    (reg_sel),
    .data_in    (data_in),
    .acc        (acc),
    .flags      (flags),
    .data_out   (data_out),
    .data_valid (data_valid)
  );

  initial clk = 1'b0;
  always #clk_half clk = ~clk;

  // watchdog over the whole run, counted in clock edges
  initial cycle_count = 0;
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the test did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $fatal(1, "run stopped by the watchdog");
    end
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  // one compare for every check, the first difference ends the run
  task automatic check_equal(input string what, input logic [7:0] got,
                             input logic [7:0] expected);
    if (got !== expected) begin
      $display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, expected);
      $display("sim failed");
      $fatal(1, "value check failed");
    end
  endtask

  // mostly valid cycles, any micro-op, any of the eight register codes
  task automatic drive_random();
    op_valid = (($urandom % 8) != 0);
    op       = z80_pkg::uop_e'(4'($urandom % 12));
    reg_sel  = z80_pkg::reg_e'(3'($urandom % 8));
    data_in  = 8'($urandom);
  endtask

  // advances the model by one edge from the inputs that the edge sampled
  task automatic apply_model();
    logic [7:0] opnd;
    logic [7:0] tmp;
    int         sel;
    int         a;
    int         r;
    sel  = int'(reg_sel);
    // codes 6 and 7 name no register and read as zero
    opnd = (sel < num_regs) ? model_main[sel] : 8'h00;
    a    = int'(model_acc);
    r    = int'(opnd);
    model_dvalid = 1'b0;
    if (op_valid) begin
      case (op)
        z80_pkg::uop_ld_reg: if (sel < num_regs) model_main[sel] = data_in;
        z80_pkg::uop_ld_a:   model_acc = data_in;
        z80_pkg::uop_mov_a:  model_acc = opnd;
        z80_pkg::uop_add: begin
          model_acc = 8'(a + r);
          model_flags[z80_pkg::flag_c] = ((a + r) > 255);
          model_flags[z80_pkg::flag_h] = (((a % 16) + (r % 16)) > 15);
          model_flags[z80_pkg::flag_s] = model_acc[7];
          model_flags[z80_pkg::flag_z] = (model_acc == 8'h00);
          model_flags[z80_pkg::flag_n] = 1'b0;
        end
        // A minus the operand, a borrow wherever the operand is the larger
        z80_pkg::uop_sub: begin
          model_acc = 8'(a - r);
          model_flags[z80_pkg::flag_c] = (a < r);
          model_flags[z80_pkg::flag_h] = ((a % 16) < (r % 16));
          model_flags[z80_pkg::flag_s] = model_acc[7];
          model_flags[z80_pkg::flag_z] = (model_acc == 8'h00);
          model_flags[z80_pkg::flag_n] = 1'b1;
        end
        z80_pkg::uop_inc_a: model_acc = 8'(a + 1);
        // the decrement leaves zero only when A was one
        z80_pkg::uop_dec_a: begin
          model_acc = 8'(a - 1);
          model_flags[z80_pkg::flag_pv] = (a != 1);
        end
        z80_pkg::uop_exx: begin
          for (int i = 0; i < num_regs; i++) begin
            tmp             = model_main[i];
            model_main[i]   = model_shadow[i];
            model_shadow[i] = tmp;
          end
        end
        z80_pkg::uop_ex_af: begin
          tmp            = model_acc;
          model_acc      = model_acc_sh;
          model_acc_sh   = tmp;
          tmp            = model_flags;
          model_flags    = model_flags_sh;
          model_flags_sh = tmp;
        end
        z80_pkg::uop_swap_a: begin
          tmp       = model_acc;
          model_acc = opnd;
          if (sel < num_regs) model_main[sel] = tmp;
        end
        z80_pkg::uop_read: begin
          model_dout   = opnd;
          model_dvalid = 1'b1;
        end
        default: ;
      endcase
    end
  endtask

  // data_out only means something while a read result is fresh
  task automatic check_outputs();
    check_equal("acc", acc, model_acc);
    check_equal("flags", flags, model_flags);
    check_equal("data_valid", {7'b0, data_valid}, {7'b0, model_dvalid});
    if (model_dvalid) check_equal("data_out", data_out, model_dout);
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h0a21e8e5));
    arst_n   = 1'b0;
    op_valid = 1'b0;
    op       = z80_pkg::uop_nop;
    reg_sel  = z80_pkg::b;
    data_in  = 8'h00;
    for (int i = 0; i < num_regs; i++) begin
      model_main[i]   = 8'h00;
      model_shadow[i] = 8'h00;
    end
    model_acc      = 8'h00;
    model_acc_sh   = 8'h00;
    model_flags    = 8'h00;
    model_flags_sh = 8'h00;
    model_dout     = 8'h00;
    model_dvalid   = 1'b0;

    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    arst_n = 1'b1;
    drive_random();
    // everything comes out of reset at zero
    #check_delay;
    check_equal("acc after reset", acc, 8'h00);
    check_equal("flags after reset", flags, 8'h00);
    check_equal("data_out after reset", data_out, 8'h00);
    check_equal("data_valid after reset", {7'b0, data_valid}, 8'h00);

    for (int k = 0; k < num_cycles; k++) begin
      @(posedge clk);
      apply_model();
      #check_delay;
      check_outputs();
      #(drive_delay - check_delay);
      drive_random();
    end

    $display("sim passed");
    $finish;
  end

endmodule

// File: z80_datapath.f
src/z80_pkg.sv
src/uop_decode.sv
src/alu8.sv
src/reg_bank.sv
src/z80_datapath.sv
tests/z80_datapath_chk.sv
tests/tb_z80_datapath.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only when the pass line shows up
verilator --binary --timing --assert --top-module tb_z80_datapath \
  -f z80_datapath.f -o sim_tb &&
./obj_dir/sim_tb 2>&1 | awk '{ print } /^sim passed$/ { ok = 1 } END { exit !ok }' &&
echo "run.sh: ok" ||
{ echo "run.sh: failed"; exit 1; }
